// File: files.f
i2c_pkg.sv
sync_fifo.sv
i2c_host_regs.sv
i2c_sequencer.sv
i2c_bit_engine.sv
i2c_master_top.sv
tb_i2c_target.sv
tb_i2c_master.sv

// File: i2c_bit_engine.sv
// Bit-level I2C engine; produces the SCL/SDA waveform for one START, STOP or byte per request
`timescale 1ns/10ps

module i2c_bit_engine (
	input logic i_clock,
	input logic i_reset,
	input i2c_pkg::bit_req_t i_req,
	input logic i_seq_req,
	input logic i_sda,
	output i2c_pkg::bit_rsp_t o_rsp,
	output logic o_eng_ack,
	output logic o_scl,
	output logic o_sda_oe,
	output logic o_sda_out
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_STOP,
		ST_BYTE,
		ST_DONE
	} eng_state_t;

	eng_state_t state;
	i2c_pkg::bit_req_t req_q;
	i2c_pkg::byte_t shift_q;
	i2c_pkg::delay_t delay_cnt;
	i2c_pkg::delay_t reload;
	logic [1:0] phase;	// Four phases per bit
	logic [3:0] bit_cnt;
	logic nack_q;
	logic tick;

	// SDA drive for the low phase of bit idx, as {oe, out}
	function automatic logic [1:0] data_drive(i2c_pkg::bit_op_t op, logic [3:0] idx,
			i2c_pkg::byte_t sh, logic ack_out);
		if (idx == 4'd8)
			return (op == i2c_pkg::OP_RX_BYTE) ? {1'b1, ~ack_out} : 2'b01;
		return (op == i2c_pkg::OP_TX_BYTE) ? {1'b1, sh[7]} : 2'b01;
	endfunction

	assign tick = (delay_cnt == '0);
	assign reload = req_q.fast ? i2c_pkg::DELAY_FAST : i2c_pkg::DELAY_SLOW;
	assign o_rsp = '{data: shift_q, nack: nack_q};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_eng_ack <= 1'b0;
			o_scl <= 1'b1;
			o_sda_oe <= 1'b0;
			o_sda_out <= 1'b1;
			delay_cnt <= '0;
			phase <= '0;
			bit_cnt <= '0;
			nack_q <= 1'b0;
		end else begin
			unique case (state)
				ST_IDLE: begin
					if (i_seq_req) begin
						req_q <= i_req;
						shift_q <= i_req.data;
						nack_q <= 1'b0;
						phase <= '0;
						bit_cnt <= '0;
						delay_cnt <= i_req.fast ? i2c_pkg::DELAY_FAST : i2c_pkg::DELAY_SLOW;
						case (i_req.op)
							i2c_pkg::OP_START: begin
								o_sda_oe <= 1'b1;
								o_sda_out <= 1'b1;
								state <= ST_START;
							end
							i2c_pkg::OP_STOP: begin
								o_scl <= 1'b0;
								o_sda_oe <= 1'b1;
								o_sda_out <= 1'b0;
								state <= ST_STOP;
							end
							default: begin
								{o_sda_oe, o_sda_out} <= data_drive(i_req.op, 4'd0,
										i_req.data, i_req.ack_out);
								state <= ST_BYTE;
							end
						endcase
					end
				end

				ST_START, ST_STOP, ST_BYTE: begin
					if (!tick) begin
						delay_cnt <= delay_cnt - 1'b1;
					end else begin
						delay_cnt <= reload;
						phase <= phase + 1'b1;
						if (state == ST_START) begin
							case (phase)
								2'd0: o_scl <= 1'b1;
								2'd1: o_sda_out <= 1'b0;	// SDA falls with SCL high
								2'd2: o_scl <= 1'b0;
								default: begin
									o_eng_ack <= 1'b1;
									state <= ST_DONE;
								end
							endcase
						end else if (state == ST_STOP) begin
							case (phase)
								2'd0: o_scl <= 1'b1;
								2'd1: begin
									o_sda_oe <= 1'b0;	// Release, SDA rises
									o_sda_out <= 1'b1;
								end
								2'd2: ;
								default: begin
									o_eng_ack <= 1'b1;
									state <= ST_DONE;
								end
							endcase
						end else begin
							case (phase)
								2'd0: ;
								2'd1: o_scl <= 1'b1;
								2'd2: begin
									// Mid SCL-high sample
									if (bit_cnt == 4'd8)
										nack_q <= (req_q.op == i2c_pkg::OP_TX_BYTE) && i_sda;
									else
										shift_q <= {shift_q[6:0], i_sda};
								end
								default: begin
									o_scl <= 1'b0;
									if (bit_cnt == 4'd8) begin
										o_sda_oe <= 1'b0;
										o_sda_out <= 1'b1;
										o_eng_ack <= 1'b1;
										state <= ST_DONE;
									end else begin
										bit_cnt <= bit_cnt + 1'b1;
										{o_sda_oe, o_sda_out} <= data_drive(req_q.op,
												bit_cnt + 1'b1, shift_q, req_q.ack_out);
									end
								end
							endcase
						end
					end
				end

				ST_DONE: begin
					if (!i_seq_req) begin
						o_eng_ack <= 1'b0;
						state <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: i2c_host_regs.sv
// Host-side register block; the CPU writes commands and reads status, RX data and counters here
`timescale 1ns/10ps

module i2c_host_regs (
	input logic i_clock,
	input logic i_reset,
	input logic i_req,
	input logic i_write,
	input i2c_pkg::reg_addr_t i_addr,
	input i2c_pkg::word_t i_wdata,
	output logic o_ack,
	output i2c_pkg::word_t o_rdata,

	output logic o_cmd_push,
	output i2c_pkg::i2c_cmd_t o_cmd,
	input logic i_cmd_full,
	input logic i_cmd_empty,

	output logic o_rx_pop,
	input i2c_pkg::byte_t i_rx_data,
	input logic i_rx_full,
	input logic i_rx_empty,

	input logic i_busy,
	input logic i_nack_pulse,
	input i2c_pkg::tag_t i_retired
);

	i2c_pkg::tag_t queued;
	logic nack_seen;
	i2c_pkg::word_t status;
	i2c_pkg::i2c_cmd_t cmd_word;

	always_comb begin
		status = '0;
		status[i2c_pkg::STAT_RX_FULL] = i_rx_full;
		status[i2c_pkg::STAT_RX_EMPTY] = i_rx_empty;
		status[i2c_pkg::STAT_CMD_FULL] = i_cmd_full;
		status[i2c_pkg::STAT_CMD_EMPTY] = i_cmd_empty;
		status[i2c_pkg::STAT_BUSY] = i_busy;
		status[i2c_pkg::STAT_NACK] = nack_seen;
	end

	// Unpack host word into a queue entry
	always_comb begin
		cmd_word.is_write = i_wdata[i2c_pkg::CMD_WRITE_BIT];
		cmd_word.fast = i_wdata[i2c_pkg::CMD_FAST_BIT];
		cmd_word.dev = i_wdata[i2c_pkg::CMD_DEV_MSB:i2c_pkg::CMD_DEV_LSB];
		cmd_word.ctrl = i_wdata[i2c_pkg::CMD_CTRL_MSB:i2c_pkg::CMD_CTRL_LSB];
		cmd_word.data_or_count = i_wdata[i2c_pkg::CMD_DATA_MSB:i2c_pkg::CMD_DATA_LSB];
		cmd_word.tag = queued + 1'b1;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ack <= 1'b0;
			o_cmd_push <= 1'b0;
			o_rx_pop <= 1'b0;
			queued <= '0;
			nack_seen <= 1'b0;
		end else begin
			o_cmd_push <= 1'b0;
			o_rx_pop <= 1'b0;

			if (i_req && !o_ack) begin
				if (i_write) begin
					if (i_addr != i2c_pkg::REG_STATUS) begin
						o_ack <= 1'b1;	// Read-only address
					end else if (!i_cmd_full) begin
						o_cmd <= cmd_word;
						o_cmd_push <= 1'b1;
						queued <= queued + 1'b1;
						o_ack <= 1'b1;
					end
				end else begin
					unique case (i_addr)
						i2c_pkg::REG_STATUS: begin
							o_rdata <= status;
							nack_seen <= 1'b0;	// Clear on read
							o_ack <= 1'b1;
						end
						i2c_pkg::REG_RXDATA: begin
							// Stall until a byte arrives
							if (!i_rx_empty) begin
								o_rdata <= {24'h0, i_rx_data};
								o_rx_pop <= 1'b1;
								o_ack <= 1'b1;
							end
						end
						i2c_pkg::REG_QUEUED: begin
							o_rdata <= queued;
							o_ack <= 1'b1;
						end
						i2c_pkg::REG_RETIRED: begin
							o_rdata <= i_retired;
							o_ack <= 1'b1;
						end
					endcase
				end
			end else if (!i_req) begin
				o_ack <= 1'b0;
			end

			if (i_nack_pulse)
				nack_seen <= 1'b1;	// New NACK beats a clearing read
		end
	end

endmodule

// File: i2c_master_top.sv
// I2C master top level; joins the host port, both queues, the sequencer and the bit engine
`timescale 1ns/10ps

module i2c_master_top (
	input logic i_clock,
	input logic i_reset,
	input logic i_req,
	input logic i_write,
	input i2c_pkg::reg_addr_t i_addr,
	input i2c_pkg::word_t i_wdata,
	input logic i_sda,
	output logic o_ack,
	output i2c_pkg::word_t o_rdata,
	output logic o_scl,
	output logic o_sda_oe,
	output logic o_sda_out
);

	logic cmd_push;
	logic cmd_pop;
	logic cmd_full;
	logic cmd_empty;
	i2c_pkg::i2c_cmd_t cmd_wdata;
	i2c_pkg::i2c_cmd_t cmd_rdata;

	logic rx_push;
	logic rx_pop;
	logic rx_full;
	logic rx_empty;
	i2c_pkg::byte_t rx_wdata;
	i2c_pkg::byte_t rx_rdata;

	logic busy;
	logic nack_pulse;
	i2c_pkg::tag_t retired;

	i2c_pkg::bit_req_t bit_req;
	i2c_pkg::bit_rsp_t bit_rsp;
	logic seq_req;
	logic eng_ack;

	i2c_host_regs host_i (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_req(i_req), .i_write(i_write), .i_addr(i_addr), .i_wdata(i_wdata),
		.o_ack(o_ack), .o_rdata(o_rdata),
		.o_cmd_push(cmd_push), .o_cmd(cmd_wdata), .i_cmd_full(cmd_full), .i_cmd_empty(cmd_empty),
		.o_rx_pop(rx_pop), .i_rx_data(rx_rdata), .i_rx_full(rx_full), .i_rx_empty(rx_empty),
		.i_busy(busy), .i_nack_pulse(nack_pulse), .i_retired(retired)
	);

	sync_fifo #(.WIDTH($bits(i2c_pkg::i2c_cmd_t)), .DEPTH(i2c_pkg::CMD_DEPTH)) cmd_fifo_i (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_push(cmd_push), .i_wdata(cmd_wdata), .i_pop(cmd_pop),
		.o_rdata(cmd_rdata), .o_empty(cmd_empty), .o_full(cmd_full)
	);

	sync_fifo #(.WIDTH($bits(i2c_pkg::byte_t)), .DEPTH(i2c_pkg::RX_DEPTH)) rx_fifo_i (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_push(rx_push), .i_wdata(rx_wdata), .i_pop(rx_pop),
		.o_rdata(rx_rdata), .o_empty(rx_empty), .o_full(rx_full)
	);

	i2c_sequencer seq_i (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_cmd(cmd_rdata), .i_cmd_empty(cmd_empty), .o_cmd_pop(cmd_pop),
		.o_rx_push(rx_push), .o_rx_data(rx_wdata), .i_rx_full(rx_full),
		.o_bit_req(bit_req), .o_seq_req(seq_req), .i_bit_rsp(bit_rsp), .i_eng_ack(eng_ack),
		.o_busy(busy), .o_nack_pulse(nack_pulse), .o_retired(retired)
	);

	i2c_bit_engine eng_i (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_req(bit_req), .i_seq_req(seq_req), .i_sda(i_sda),
		.o_rsp(bit_rsp), .o_eng_ack(eng_ack),
		.o_scl(o_scl), .o_sda_oe(o_sda_oe), .o_sda_out(o_sda_out)
	);

endmodule

// File: i2c_pkg.sv
// Shared types, bus timing and the host register map; referenced by scoped name from every module
package i2c_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [6:0] dev_addr_t;
	typedef logic [31:0] tag_t;
	typedef logic [31:0] word_t;
	typedef logic [1:0] reg_addr_t;
	typedef logic [4:0] delay_t;	// Quarter-period counter
	typedef logic [3:0] count_t;	// Read byte count

	// Quarter SCL period, in clocks minus one
	localparam delay_t DELAY_SLOW = 5'd24;
	localparam delay_t DELAY_FAST = 5'd6;

	localparam int CMD_DEPTH = 16;
	localparam int RX_DEPTH = 16;

	localparam reg_addr_t REG_STATUS = 2'd0;
	localparam reg_addr_t REG_RXDATA = 2'd1;
	localparam reg_addr_t REG_QUEUED = 2'd2;
	localparam reg_addr_t REG_RETIRED = 2'd3;

	// Status word bits
	localparam int STAT_RX_FULL = 0;
	localparam int STAT_RX_EMPTY = 1;
	localparam int STAT_CMD_FULL = 2;
	localparam int STAT_CMD_EMPTY = 3;
	localparam int STAT_BUSY = 4;
	localparam int STAT_NACK = 5;

	// Host command word layout
	localparam int CMD_WRITE_BIT = 0;
	localparam int CMD_FAST_BIT = 1;
	localparam int CMD_DEV_LSB = 8;
	localparam int CMD_DEV_MSB = 14;
	localparam int CMD_CTRL_LSB = 16;
	localparam int CMD_CTRL_MSB = 23;
	localparam int CMD_DATA_LSB = 24;
	localparam int CMD_DATA_MSB = 31;
	localparam int CMD_COUNT_MSB = 27;

	typedef struct packed {
		logic is_write;
		logic fast;
		dev_addr_t dev;
		byte_t ctrl;
		byte_t data_or_count;	// Write data, or read count in low nibble
		tag_t tag;
	} i2c_cmd_t;

	typedef enum logic [1:0] {
		OP_START,
		OP_STOP,
		OP_TX_BYTE,
		OP_RX_BYTE
	} bit_op_t;

	typedef struct packed {
		bit_op_t op;
		logic fast;
		byte_t data;
		logic ack_out;	// Master ACKs the received byte
	} bit_req_t;

	typedef struct packed {
		byte_t data;
		logic nack;
	} bit_rsp_t;

endpackage

// File: i2c_sequencer.sv
// Transaction sequencer; pops one command and walks it through the bit engine operations
`timescale 1ns/10ps

module i2c_sequencer (
	input logic i_clock,
	input logic i_reset,

	input i2c_pkg::i2c_cmd_t i_cmd,
	input logic i_cmd_empty,
	output logic o_cmd_pop,

	output logic o_rx_push,
	output i2c_pkg::byte_t o_rx_data,
	input logic i_rx_full,

	output i2c_pkg::bit_req_t o_bit_req,
	output logic o_seq_req,
	input i2c_pkg::bit_rsp_t i_bit_rsp,
	input logic i_eng_ack,

	output logic o_busy,
	output logic o_nack_pulse,
	output i2c_pkg::tag_t o_retired
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_START,
		S_ADDR_W,
		S_CTRL,
		S_DATA,
		S_RESTART,
		S_ADDR_R,
		S_RX,
		S_STOP,
		S_RETIRE
	} seq_state_t;

	seq_state_t state;
	i2c_pkg::i2c_cmd_t cmd_q;
	i2c_pkg::count_t remaining;
	i2c_pkg::count_t count_in;
	i2c_pkg::bit_req_t next_req;
	logic can_issue;

	assign count_in = i_cmd.data_or_count[i2c_pkg::CMD_COUNT_MSB-i2c_pkg::CMD_DATA_LSB:0];

	// RX waits for room in the receive queue
	assign can_issue = !i_eng_ack && !(state == S_RX && i_rx_full);

	always_comb begin
		next_req.op = i2c_pkg::OP_START;
		next_req.fast = cmd_q.fast;
		next_req.data = '0;
		next_req.ack_out = 1'b0;
		case (state)
			S_ADDR_W: begin
				next_req.op = i2c_pkg::OP_TX_BYTE;
				next_req.data = {cmd_q.dev, 1'b0};
			end
			S_CTRL: begin
				next_req.op = i2c_pkg::OP_TX_BYTE;
				next_req.data = cmd_q.ctrl;
			end
			S_DATA: begin
				next_req.op = i2c_pkg::OP_TX_BYTE;
				next_req.data = cmd_q.data_or_count;
			end
			S_ADDR_R: begin
				next_req.op = i2c_pkg::OP_TX_BYTE;
				next_req.data = {cmd_q.dev, 1'b1};
			end
			S_RX: begin
				next_req.op = i2c_pkg::OP_RX_BYTE;
				next_req.ack_out = (remaining != 4'd1);	// NACK the last byte
			end
			S_STOP: next_req.op = i2c_pkg::OP_STOP;
			default: ;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= S_IDLE;
			o_cmd_pop <= 1'b0;
			o_rx_push <= 1'b0;
			o_seq_req <= 1'b0;
			o_busy <= 1'b0;
			o_nack_pulse <= 1'b0;
			o_retired <= '0;
		end else begin
			o_cmd_pop <= 1'b0;
			o_rx_push <= 1'b0;
			o_nack_pulse <= 1'b0;

			case (state)
				S_IDLE: begin
					if (!i_cmd_empty) begin
						cmd_q <= i_cmd;
						remaining <= (count_in == '0) ? 4'd1 : count_in;
						o_cmd_pop <= 1'b1;
						o_busy <= 1'b1;
						state <= S_START;
					end
				end
				S_RETIRE: begin
					o_retired <= cmd_q.tag;
					o_busy <= 1'b0;
					state <= S_IDLE;
				end
				default: begin
					if (!o_seq_req) begin
						if (can_issue) begin
							o_bit_req <= next_req;
							o_seq_req <= 1'b1;
						end
					end else if (i_eng_ack) begin
						o_seq_req <= 1'b0;
						o_nack_pulse <= i_bit_rsp.nack;
						case (state)
							S_START: state <= S_ADDR_W;
							S_ADDR_W: state <= i_bit_rsp.nack ? S_STOP : S_CTRL;
							S_CTRL: begin
								if (i_bit_rsp.nack)
									state <= S_STOP;
								else
									state <= cmd_q.is_write ? S_DATA : S_RESTART;
							end
							S_DATA: state <= S_STOP;
							S_RESTART: state <= S_ADDR_R;
							S_ADDR_R: state <= i_bit_rsp.nack ? S_STOP : S_RX;
							S_RX: begin
								o_rx_data <= i_bit_rsp.data;
								o_rx_push <= 1'b1;
								remaining <= remaining - 1'b1;
								state <= (remaining == 4'd1) ? S_STOP : S_RX;
							end
							default: state <= S_RETIRE;	// After STOP
						endcase
					end
				end
			endcase
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the I2C master testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --top-module tb_i2c_master -f files.f -o tb_sim \
	> build.log 2>&1 \
	&& ./obj_dir/tb_sim > "$LOG" 2>&1 \
	|| { echo "Build or simulation error, see build.log and $LOG"; exit 1; }
grep -qF '** FAIL **' "$LOG" \
	&& { echo "Simulation failed, see $LOG"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

// File: sync_fifo.sv
// First-word-fall-through FIFO, instantiated for both the command and receive queues
`timescale 1ns/10ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_push,
	input logic [WIDTH-1:0] i_wdata,
	input logic i_pop,
	output logic [WIDTH-1:0] o_rdata,
	output logic o_empty,
	output logic o_full
);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	assign o_empty = (count == '0);
	assign o_full = (count == ($clog2(DEPTH+1))'(DEPTH));
	assign o_rdata = mem[rd_ptr];	// Head is always visible

	always_ff @(posedge i_clock) begin
		if (do_push)
			mem[wr_ptr] <= i_wdata;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: tb_i2c_master.sv
// Testbench top for the I2C master; drives the host port, models the bus and checks the results
`timescale 1ns/10ps

module tb_i2c_master;

	localparam int NUM_WRITES = 6;
	localparam int ACK_TIMEOUT = 20000;
	localparam int POLL_LIMIT = 10000;
	localparam logic [6:0] TARGET_DEV = 7'h50;
	localparam logic [6:0] ABSENT_DEV = 7'h23;

	logic clock;
	logic reset;
	logic host_req;
	logic host_write;
	i2c_pkg::reg_addr_t host_addr;
	i2c_pkg::word_t host_wdata;
	logic host_ack;
	i2c_pkg::word_t host_rdata;
	logic scl;
	logic sda_oe;
	logic sda_out;
	logic sda_pull;
	logic sda;
	logic [7:0] ack_log;
	logic [3:0] ack_count;

	i2c_pkg::byte_t ref_mem [256];
	i2c_pkg::byte_t ctrl_list [NUM_WRITES];
	i2c_pkg::byte_t data_list [NUM_WRITES];
	logic rate_q [$];	// Fast bit per outstanding command
	integer seed;
	int checks;
	int mismatches;
	int other_errors;
	int slow_bits;
	int fast_bits;

	logic mon_scl_d;
	logic mon_sda_d;
	logic in_high;
	logic sda_moved;
	int high_len;

	assign sda = sda_oe ? sda_out : !sda_pull;	// Open-drain with pull-up

	i2c_master_top dut_i (
		.i_clock(clock), .i_reset(reset),
		.i_req(host_req), .i_write(host_write), .i_addr(host_addr), .i_wdata(host_wdata),
		.i_sda(sda),
		.o_ack(host_ack), .o_rdata(host_rdata),
		.o_scl(scl), .o_sda_oe(sda_oe), .o_sda_out(sda_out)
	);

	tb_i2c_target target_i (
		.i_clock(clock), .i_reset(reset), .i_scl(scl), .i_sda(sda),
		.o_sda_pull(sda_pull), .o_ack_log(ack_log), .o_ack_count(ack_count)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] make_cmd(input logic is_write, input logic fast,
			input logic [6:0] dev, input logic [7:0] ctrl, input logic [7:0] data);
		return {data, ctrl, 1'b0, dev, 6'b0, fast, is_write};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			mismatches++;
			$display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		@(posedge clock);
		while (host_ack !== level && cycles < ACK_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		if (host_ack !== level) begin
			other_errors++;
			$display("Timeout: host acknowledge never went to %0d", level);
		end
	endtask

	task automatic write_reg(input i2c_pkg::reg_addr_t addr, input logic [31:0] data);
		@(posedge clock);
		host_req <= 1'b1;
		host_write <= 1'b1;
		host_addr <= addr;
		host_wdata <= data;
		wait_ack(1'b1);
		host_req <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic read_reg(input i2c_pkg::reg_addr_t addr, output logic [31:0] data);
		@(posedge clock);
		host_req <= 1'b1;
		host_write <= 1'b0;
		host_addr <= addr;
		wait_ack(1'b1);
		data = host_rdata;
		host_req <= 1'b0;
		wait_ack(1'b0);
	endtask

	// Until the sequencer is idle with nothing queued
	task automatic poll_idle();
		logic [31:0] stat;
		int polls;
		stat = 32'h10;
		polls = 0;
		while ((stat[i2c_pkg::STAT_BUSY] || !stat[i2c_pkg::STAT_CMD_EMPTY])
				&& polls < POLL_LIMIT) begin
			read_reg(i2c_pkg::REG_STATUS, stat);
			polls++;
		end
		if (stat[i2c_pkg::STAT_BUSY] || !stat[i2c_pkg::STAT_CMD_EMPTY]) begin
			other_errors++;
			$display("Timeout: controller did not return to idle");
		end
	endtask

	task automatic poll_retired(input logic [31:0] tag);
		logic [31:0] rd;
		int polls;
		polls = 0;
		read_reg(i2c_pkg::REG_RETIRED, rd);
		while (rd !== tag && polls < POLL_LIMIT) begin
			read_reg(i2c_pkg::REG_RETIRED, rd);
			polls++;
		end
		if (rd !== tag) begin
			other_errors++;
			$display("Timeout: command %0d never retired", tag);
		end
	endtask

	task automatic verify_high_time(input int clocks);
		if (rate_q.size() == 0) begin
			other_errors++;
			$display("SCL data bit seen with no command outstanding");
		end else if (rate_q[0]) begin
			fast_bits++;
			check_value("scl high time (fast)", clocks, 32'd14);
		end else begin
			slow_bits++;
			check_value("scl high time (slow)", clocks, 32'd50);
		end
	endtask

	// Data bits are SCL high pulses with steady SDA
	// A STOP retires the head rate
	always @(posedge clock) begin
		if (reset) begin
			mon_scl_d <= 1'b1;
			mon_sda_d <= 1'b1;
			in_high <= 1'b0;
			sda_moved <= 1'b0;
			high_len <= 0;
		end else begin
			mon_scl_d <= scl;
			mon_sda_d <= sda;
			if (scl && !mon_scl_d) begin
				in_high <= 1'b1;
				sda_moved <= 1'b0;
				high_len <= 1;
			end else if (scl) begin
				high_len <= high_len + 1;
				if (sda != mon_sda_d)
					sda_moved <= 1'b1;
			end else if (mon_scl_d && in_high) begin
				in_high <= 1'b0;
				if (!sda_moved)
					verify_high_time(high_len);
			end
			if (scl && mon_scl_d && sda && !mon_sda_d && rate_q.size() > 0)
				void'(rate_q.pop_front());
		end
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] rnd;
		logic fast;
		i2c_pkg::byte_t rd_ctrl;
		clock = 1'b0;
		reset = 1'b1;
		host_req = 1'b0;
		host_write = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		seed = 32'hc7ae_edcd;
		checks = 0;
		mismatches = 0;
		other_errors = 0;
		slow_bits = 0;
		fast_bits = 0;
		for (int i = 0; i < 256; i++)
			ref_mem[i] = 8'(i * 29 + 59);
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		// Idle state after reset
		check_value("o_ack", {31'h0, host_ack}, 32'h0);
		check_value("o_sda_oe", {31'h0, sda_oe}, 32'h0);
		check_value("o_sda_out", {31'h0, sda_out}, 32'h1);
		check_value("o_scl", {31'h0, scl}, 32'h1);
		read_reg(i2c_pkg::REG_STATUS, rd);
		check_value("status after reset", rd, 32'h0A);
		read_reg(i2c_pkg::REG_QUEUED, rd);
		check_value("queued after reset", rd, 32'h0);
		read_reg(i2c_pkg::REG_RETIRED, rd);
		check_value("retired after reset", rd, 32'h0);

		// Back-to-back writes at alternating rates
		for (int i = 0; i < NUM_WRITES; i++) begin
			rnd = $random(seed);
			ctrl_list[i] = rnd[7:0];
			data_list[i] = rnd[15:8];
			if (i == NUM_WRITES - 1)
				ctrl_list[i] = ctrl_list[1];	// Overwrites an earlier write
			fast = i[0];
			rate_q.push_back(fast);
			write_reg(i2c_pkg::REG_STATUS,
					make_cmd(1'b1, fast, TARGET_DEV, ctrl_list[i], data_list[i]));
			ref_mem[ctrl_list[i]] = data_list[i];
		end
		read_reg(i2c_pkg::REG_QUEUED, rd);
		check_value("queued after writes", rd, NUM_WRITES);
		poll_idle();
		read_reg(i2c_pkg::REG_RETIRED, rd);
		check_value("retired after writes", rd, NUM_WRITES);
		for (int a = 0; a < 256; a++)
			check_value($sformatf("target mem[0x%02h]", a), {24'h0, target_i.mem[a]},
					{24'h0, ref_mem[a]});

		// Three-byte read at slow rate
		rd_ctrl = ctrl_list[0];
		rate_q.push_back(1'b0);
		write_reg(i2c_pkg::REG_STATUS, make_cmd(1'b0, 1'b0, TARGET_DEV, rd_ctrl, 8'd3));
		for (int j = 0; j < 3; j++) begin
			read_reg(i2c_pkg::REG_RXDATA, rd);
			check_value("rx data", rd, {24'h0, ref_mem[8'(rd_ctrl + j)]});
		end
		poll_retired(NUM_WRITES + 1);
		check_value("target ack count", {28'h0, ack_count}, 32'd3);
		check_value("target ack log", {29'h0, ack_log[2:0]}, 32'h1);	// ACK, ACK, NACK
		read_reg(i2c_pkg::REG_STATUS, rd);
		check_value("status after read", rd, 32'h0A);
		read_reg(i2c_pkg::REG_QUEUED, rd);
		check_value("queued after read", rd, NUM_WRITES + 1);

		// Read from a device that never answers, so no byte may arrive
		rnd = $random(seed);
		rate_q.push_back(1'b1);
		write_reg(i2c_pkg::REG_STATUS, make_cmd(1'b0, 1'b1, ABSENT_DEV, rnd[7:0], 8'd2));
		poll_retired(NUM_WRITES + 2);
		read_reg(i2c_pkg::REG_STATUS, rd);
		check_value("status with nack", rd, 32'h2A);
		read_reg(i2c_pkg::REG_STATUS, rd);
		check_value("status after nack clear", rd, 32'h0A);
		read_reg(i2c_pkg::REG_QUEUED, rd);
		check_value("queued at end", rd, NUM_WRITES + 2);
		read_reg(i2c_pkg::REG_RETIRED, rd);
		check_value("retired at end", rd, NUM_WRITES + 2);

		check_value("o_scl at end", {31'h0, scl}, 32'h1);
		check_value("o_sda_oe at end", {31'h0, sda_oe}, 32'h0);
		assert (slow_bits != 0 && fast_bits != 0) else begin
			other_errors++;
			$display("SCL timing was not measured at both rates");
		end
		assert (rate_q.size() == 0) else begin
			other_errors++;
			$display("Fewer STOP conditions on the bus than commands issued");
		end

		$display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches,
				other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: tb_i2c_target.sv
// Behavioral I2C target for the testbench, answering one fixed address from a 256-byte register file
`timescale 1ns/10ps

module tb_i2c_target (
	input logic i_clock,
	input logic i_reset,
	input logic i_scl,
	input logic i_sda,
	output logic o_sda_pull,
	output logic [7:0] o_ack_log,	// Master ACK bits since START, newest in bit 0
	output logic [3:0] o_ack_count
);

	localparam logic [6:0] OWN_ADDR = 7'h50;

	typedef enum logic [2:0] {
		T_IDLE,
		T_ADDR,
		T_CTRL,
		T_WDATA,
		T_READ,
		T_IGNORE
	} tgt_state_t;

	i2c_pkg::byte_t mem [256];
	tgt_state_t state;
	i2c_pkg::byte_t shift;
	i2c_pkg::byte_t ptr;
	logic [3:0] bit_idx;
	logic scl_d;
	logic sda_d;
	logic skip_fall;	// SCL fall that ends the START itself
	logic rw;

	always @(posedge i_clock) begin
		if (i_reset) begin
			state <= T_IDLE;
			o_sda_pull <= 1'b0;
			o_ack_log <= '0;
			o_ack_count <= '0;
			scl_d <= 1'b1;
			sda_d <= 1'b1;
			bit_idx <= '0;
			skip_fall <= 1'b0;
			shift <= '0;
			ptr <= '0;
			rw <= 1'b0;
			for (int i = 0; i < 256; i++)
				mem[i] <= 8'(i * 29 + 59);
		end else begin
			scl_d <= i_scl;
			sda_d <= i_sda;
			if (i_scl && scl_d && sda_d && !i_sda) begin
				// START or repeated START
				state <= T_ADDR;
				bit_idx <= '0;
				skip_fall <= 1'b1;
				o_ack_log <= '0;
				o_ack_count <= '0;
			end else if (i_scl && scl_d && !sda_d && i_sda) begin
				state <= T_IDLE;	// STOP
				o_sda_pull <= 1'b0;
			end else if (i_scl && !scl_d) begin
				if (bit_idx == 4'd8) begin
					if (state == T_READ) begin
						o_ack_log <= {o_ack_log[6:0], i_sda};
						o_ack_count <= o_ack_count + 1'b1;
					end
				end else if (state inside {T_ADDR, T_CTRL, T_WDATA}) begin
					shift <= {shift[6:0], i_sda};
				end
			end else if (!i_scl && scl_d) begin
				if (skip_fall) begin
					skip_fall <= 1'b0;
				end else if (bit_idx == 4'd7) begin
					bit_idx <= 4'd8;
					case (state)
						T_ADDR: begin
							if (shift[7:1] == OWN_ADDR) begin
								rw <= shift[0];
								o_sda_pull <= 1'b1;
							end else begin
								state <= T_IGNORE;
							end
						end
						T_CTRL: begin
							ptr <= shift;
							o_sda_pull <= 1'b1;
						end
						T_WDATA: begin
							mem[ptr] <= shift;
							ptr <= ptr + 1'b1;	// Auto-increment
							o_sda_pull <= 1'b1;
						end
						default: o_sda_pull <= 1'b0;	// Master owns the ACK bit
					endcase
				end else if (bit_idx == 4'd8) begin
					bit_idx <= '0;
					o_sda_pull <= 1'b0;
					case (state)
						T_ADDR: begin
							if (rw) begin
								shift <= mem[ptr];
								ptr <= ptr + 1'b1;
								o_sda_pull <= ~mem[ptr][7];
								state <= T_READ;
							end else begin
								state <= T_CTRL;
							end
						end
						T_CTRL: state <= T_WDATA;
						T_READ: begin
							if (!o_ack_log[0]) begin
								shift <= mem[ptr];
								ptr <= ptr + 1'b1;
								o_sda_pull <= ~mem[ptr][7];
							end else begin
								state <= T_IDLE;	// NACK ends the read
							end
						end
						default: ;
					endcase
				end else begin
					bit_idx <= bit_idx + 1'b1;
					if (state == T_READ) begin
						shift <= {shift[6:0], 1'b0};
						o_sda_pull <= ~shift[6];
					end
				end
			end
		end
	end

endmodule
